// File: isa_pkg.sv
// ==========================================================
// isa_pkg
// instruction word layout, opcode encoding and data widths
// for the in-order integer back end
// ==========================================================
package isa_pkg;

    localparam int XLEN    = 32;
    localparam int REG_AW  = 5;
    localparam int NUM_GPR = 1 << REG_AW;

    typedef enum logic [3:0] {
        OP_ADD  = 4'h0,
        OP_SUB  = 4'h1,
        OP_AND  = 4'h2,
        OP_OR   = 4'h3,
        OP_XOR  = 4'h4,
        OP_ADDI = 4'h5,
        OP_LW   = 4'h6,
        OP_SW   = 4'h7
    } op_e;

    // field positions in the instruction word
    localparam int OPC_HI = 31;
    localparam int OPC_LO = 28;
    localparam int RD_HI  = 27;
    localparam int RD_LO  = 23;
    localparam int RS1_HI = 22;
    localparam int RS1_LO = 18;
    localparam int RS2_HI = 17;
    localparam int RS2_LO = 13;
    localparam int IMM_HI = 11;
    localparam int IMM_LO = 0;
    localparam int IMM_W  = IMM_HI - IMM_LO + 1;

endpackage

// File: pipe_pkg.sv
// ==========================================================
// pipe_pkg
// decoded control word that travels from issue to EX
// ==========================================================
package pipe_pkg;

    typedef struct packed {
        isa_pkg::op_e                op;
        logic [isa_pkg::REG_AW-1:0]  rd;
        logic [isa_pkg::REG_AW-1:0]  rs1;
        logic [isa_pkg::REG_AW-1:0]  rs2;
        // sign-extended immediate
        logic [isa_pkg::XLEN-1:0]    imm;
        logic                        write_gpr;
        logic                        mem_to_reg;
    } ex_ctrl_t;

    // no register write, no memory access
    localparam ex_ctrl_t CTRL_BUBBLE = '0;

endpackage

// File: stage_if.sv
// ==========================================================
// stage_if
// destination, write flags and result of one pipe stage,
// watched by the hazard logic and the register file
// ==========================================================
interface stage_if;
    import isa_pkg::*;

    logic [REG_AW-1:0] rd;
    logic              write_gpr;
    logic              mem_to_reg;
    logic [XLEN-1:0]   data;

    modport drv (
        output rd,
        output write_gpr,
        output mem_to_reg,
        output data
    );

    modport mon (
        input rd,
        input write_gpr,
        input mem_to_reg,
        input data
    );

endinterface

// File: issue_stage.sv
// ==========================================================
// issue_stage
// issue register, instruction decode and the 32-entry
// register file, which is written back from WB
// ==========================================================
module issue_stage (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        instr_valid,
    input  logic [isa_pkg::XLEN-1:0]    instr,
    input  logic                        stall,
    stage_if.mon                        wb,
    output logic [isa_pkg::REG_AW-1:0]  rs1,
    output logic [isa_pkg::REG_AW-1:0]  rs2,
    output pipe_pkg::ex_ctrl_t          ctrl,
    output logic [isa_pkg::XLEN-1:0]    rs1_data,
    output logic [isa_pkg::XLEN-1:0]    rs2_data
);
    import isa_pkg::*;
    import pipe_pkg::*;

    logic            ir_valid;
    logic [XLEN-1:0] ir_word;
    logic [XLEN-1:0] gpr [NUM_GPR];
    op_e             opcode;

    // issue register frozen while the pipe stalls
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ir_valid <= 1'b0;
        end else if (!stall) begin
            ir_valid <= instr_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            ir_word <= instr;
        end
    end

    assign rs1    = ir_word[RS1_HI:RS1_LO];
    assign rs2    = ir_word[RS2_HI:RS2_LO];
    assign opcode = op_e'(ir_word[OPC_HI:OPC_LO]);

    // ==========================================================
    // decode
    // ==========================================================
    always_comb begin
        ctrl = CTRL_BUBBLE;
        if (ir_valid) begin
            ctrl.op  = opcode;
            ctrl.rd  = ir_word[RD_HI:RD_LO];
            ctrl.rs1 = rs1;
            ctrl.rs2 = rs2;
            ctrl.imm = {{(XLEN - IMM_W){ir_word[IMM_HI]}}, ir_word[IMM_HI:IMM_LO]};
            case (opcode)
                OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_ADDI: begin
                    ctrl.write_gpr = 1'b1;
                end
                OP_LW: begin
                    ctrl.write_gpr  = 1'b1;
                    ctrl.mem_to_reg = 1'b1;
                end
                // store data comes from rs2
                OP_SW: begin
                    ctrl.write_gpr = 1'b0;
                end
                default: begin
                    ctrl = CTRL_BUBBLE;
                end
            endcase
            // x0 is never a destination
            if (ctrl.rd == '0) begin
                ctrl.write_gpr = 1'b0;
            end
        end
    end

    // register file keeps x0 at zero
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < NUM_GPR; i++) begin
                gpr[i] <= '0;
            end
        end else if (wb.write_gpr && (wb.rd != '0)) begin
            gpr[wb.rd] <= wb.data;
        end
    end

    assign rs1_data = gpr[rs1];
    assign rs2_data = gpr[rs2];

endmodule

// File: ex_seg_reg.sv
// ==========================================================
// ex_seg_reg
// ID-EX segment register, holds under stall and takes
// the WB result in place of a stale register-file read
// ==========================================================
module ex_seg_reg (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      stall,
    input  pipe_pkg::ex_ctrl_t        ctrl_in,
    input  logic [isa_pkg::XLEN-1:0]  rs1_data_in,
    input  logic [isa_pkg::XLEN-1:0]  rs2_data_in,
    input  logic                      seg_hazard_rs1,
    input  logic                      seg_hazard_rs2,
    input  logic [isa_pkg::XLEN-1:0]  seg_data_rs1,
    input  logic [isa_pkg::XLEN-1:0]  seg_data_rs2,
    output pipe_pkg::ex_ctrl_t        ctrl_out,
    output logic [isa_pkg::XLEN-1:0]  op_a,
    output logic [isa_pkg::XLEN-1:0]  op_b
);
    import pipe_pkg::*;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ctrl_out <= CTRL_BUBBLE;
        end else if (!stall) begin
            ctrl_out <= ctrl_in;
        end
    end

    // while stalled the bypass targets the held instruction,
    // so a result leaving WB during the freeze is kept
    always_ff @(posedge clk) begin
        if (seg_hazard_rs1) begin
            op_a <= seg_data_rs1;
        end else if (!stall) begin
            op_a <= rs1_data_in;
        end
        if (seg_hazard_rs2) begin
            op_b <= seg_data_rs2;
        end else if (!stall) begin
            op_b <= rs2_data_in;
        end
    end

endmodule

// File: mem_forward.sv
// ==========================================================
// mem_forward
// hazard detection, bypass data selection and the global
// stall for the whole pipe
// ==========================================================
module mem_forward (
    input  logic                        instr_valid,
    input  logic                        mem_rvalid,
    input  logic                        mem_wready,
    input  logic [isa_pkg::REG_AW-1:0]  id_rs1,
    input  logic [isa_pkg::REG_AW-1:0]  id_rs2,
    input  logic [isa_pkg::REG_AW-1:0]  ex_rs1,
    input  logic [isa_pkg::REG_AW-1:0]  ex_rs2,
    stage_if.mon                        mem_bus,
    stage_if.mon                        wb_bus,
    input  logic [isa_pkg::XLEN-1:0]    mem_rdata,
    output logic                        stall,
    output logic                        flush_me,
    output logic                        ex_hazard_rs1,
    output logic                        ex_hazard_rs2,
    output logic [isa_pkg::XLEN-1:0]    ex_data_rs1,
    output logic [isa_pkg::XLEN-1:0]    ex_data_rs2,
    output logic                        seg_hazard_rs1,
    output logic                        seg_hazard_rs2,
    output logic [isa_pkg::XLEN-1:0]    seg_data_rs1,
    output logic [isa_pkg::XLEN-1:0]    seg_data_rs2
);
    import isa_pkg::*;

    logic              mem_live;
    logic              wb_live;
    logic              first_rs1, first_rs2;
    logic              load_use_rs1, load_use_rs2;
    logic              second_rs1, second_rs2;
    logic [REG_AW-1:0] seg_rs1, seg_rs2;

    // a stage bypasses only when it writes a real register
    assign mem_live = mem_bus.write_gpr && (mem_bus.rd != '0);
    assign wb_live  = wb_bus.write_gpr && (wb_bus.rd != '0);

    // first stage takes the ALU result sitting in MEM
    assign first_rs1 = mem_live && !mem_bus.mem_to_reg && (ex_rs1 == mem_bus.rd);
    assign first_rs2 = mem_live && !mem_bus.mem_to_reg && (ex_rs2 == mem_bus.rd);

    // load-use takes the memory read data from MEM
    assign load_use_rs1 = mem_live && mem_bus.mem_to_reg && (ex_rs1 == mem_bus.rd);
    assign load_use_rs2 = mem_live && mem_bus.mem_to_reg && (ex_rs2 == mem_bus.rd);

    // second stage forwards the WB result into EX
    assign second_rs1 = wb_live && (ex_rs1 == wb_bus.rd);
    assign second_rs2 = wb_live && (ex_rs2 == wb_bus.rd);

    assign ex_hazard_rs1 = first_rs1 | load_use_rs1 | second_rs1;
    assign ex_hazard_rs2 = first_rs2 | load_use_rs2 | second_rs2;

    // MEM holds the younger result and wins over WB
    assign ex_data_rs1 = first_rs1    ? mem_bus.data :
                         load_use_rs1 ? mem_rdata    :
                         second_rs1   ? wb_bus.data  : '0;
    assign ex_data_rs2 = first_rs2    ? mem_bus.data :
                         load_use_rs2 ? mem_rdata    :
                         second_rs2   ? wb_bus.data  : '0;

    // ==========================================================
    // third stage forwards the WB result into the segment register
    // ==========================================================
    // under stall the segment register keeps its instruction
    assign seg_rs1 = stall ? ex_rs1 : id_rs1;
    assign seg_rs2 = stall ? ex_rs2 : id_rs2;

    assign seg_hazard_rs1 = wb_live && (seg_rs1 == wb_bus.rd);
    assign seg_hazard_rs2 = wb_live && (seg_rs2 == wb_bus.rd);
    assign seg_data_rs1   = {XLEN{seg_hazard_rs1}} & wb_bus.data;
    assign seg_data_rs2   = {XLEN{seg_hazard_rs2}} & wb_bus.data;

    // whole pipe freezes until fetch and memory are both done
    assign stall    = !(instr_valid && mem_rvalid && mem_wready);
    assign flush_me = stall;

endmodule

// File: exec_mem_wb.sv
// ==========================================================
// exec_mem_wb
// ALU, EX-MEM register, data memory with a fixed access
// latency, MEM-WB register and write-back
// ==========================================================
module exec_mem_wb #(
    parameter int MEM_DEPTH = 64,
    parameter int MEM_LAT   = 2
) (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      stall,
    input  logic                      flush_me,
    input  pipe_pkg::ex_ctrl_t        ctrl,
    input  logic [isa_pkg::XLEN-1:0]  op_a,
    input  logic [isa_pkg::XLEN-1:0]  op_b,
    input  logic                      ex_hazard_rs1,
    input  logic                      ex_hazard_rs2,
    input  logic [isa_pkg::XLEN-1:0]  ex_data_rs1,
    input  logic [isa_pkg::XLEN-1:0]  ex_data_rs2,
    stage_if.drv                      mem_bus,
    stage_if.drv                      wb_bus,
    output logic [isa_pkg::XLEN-1:0]  mem_rdata,
    output logic                      mem_rvalid,
    output logic                      mem_wready
);
    import isa_pkg::*;

    localparam int AW    = $clog2(MEM_DEPTH);
    localparam int CNT_W = $clog2(MEM_LAT + 1);

    logic [XLEN-1:0]   src_a, src_b, alu_out;
    op_e               em_op;
    logic [REG_AW-1:0] em_rd;
    logic              em_wgpr, em_m2r;
    logic [XLEN-1:0]   em_alu, em_sdata;
    logic [CNT_W-1:0]  wait_cnt;
    logic [AW-1:0]     mem_idx;
    logic [XLEN-1:0]   dmem [MEM_DEPTH];
    logic [REG_AW-1:0] wb_rd;
    logic              wb_wgpr, wb_m2r;
    logic [XLEN-1:0]   wb_data;

    // ==========================================================
    // EX
    // ==========================================================
    assign src_a = ex_hazard_rs1 ? ex_data_rs1 : op_a;
    assign src_b = ex_hazard_rs2 ? ex_data_rs2 : op_b;

    always_comb begin
        case (ctrl.op)
            OP_ADD:                alu_out = src_a + src_b;
            OP_SUB:                alu_out = src_a - src_b;
            OP_AND:                alu_out = src_a & src_b;
            OP_OR:                 alu_out = src_a | src_b;
            OP_XOR:                alu_out = src_a ^ src_b;
            // addi and the load/store address
            OP_ADDI, OP_LW, OP_SW: alu_out = src_a + ctrl.imm;
            default:               alu_out = '0;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            em_op   <= OP_ADD;
            em_rd   <= '0;
            em_wgpr <= 1'b0;
            em_m2r  <= 1'b0;
        end else if (!stall) begin
            em_op   <= ctrl.op;
            em_rd   <= ctrl.rd;
            em_wgpr <= ctrl.write_gpr;
            em_m2r  <= ctrl.mem_to_reg;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            em_alu   <= alu_out;
            em_sdata <= src_b;
        end
    end

    // ==========================================================
    // MEM
    // ==========================================================
    // word address wraps at the memory size
    assign mem_idx   = AW'((em_alu >> 2) % MEM_DEPTH);
    assign mem_rdata = dmem[mem_idx];

    // access wait loaded as a load or store enters MEM
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wait_cnt <= '0;
        end else if (!stall) begin
            wait_cnt <= (ctrl.op == OP_LW || ctrl.op == OP_SW) ? CNT_W'(MEM_LAT) : '0;
        end else if (wait_cnt != '0) begin
            wait_cnt <= wait_cnt - 1'b1;
        end
    end

    assign mem_rvalid = !((em_op == OP_LW) && (wait_cnt != '0));
    assign mem_wready = !((em_op == OP_SW) && (wait_cnt != '0));

    // store commits once, on the edge it leaves MEM
    always_ff @(posedge clk) begin
        if (!stall && (em_op == OP_SW)) begin
            dmem[mem_idx] <= em_sdata;
        end
    end

    assign mem_bus.rd         = em_rd;
    assign mem_bus.write_gpr  = em_wgpr;
    assign mem_bus.mem_to_reg = em_m2r;
    assign mem_bus.data       = em_alu;

    // ==========================================================
    // WB
    // ==========================================================
    // bubble while the pipe is frozen
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb_rd   <= '0;
            wb_wgpr <= 1'b0;
            wb_m2r  <= 1'b0;
        end else if (flush_me) begin
            wb_rd   <= '0;
            wb_wgpr <= 1'b0;
            wb_m2r  <= 1'b0;
        end else begin
            wb_rd   <= em_rd;
            wb_wgpr <= em_wgpr;
            wb_m2r  <= em_m2r;
        end
    end

    always_ff @(posedge clk) begin
        if (!flush_me) begin
            wb_data <= em_m2r ? mem_rdata : em_alu;
        end
    end

    assign wb_bus.rd         = wb_rd;
    assign wb_bus.write_gpr  = wb_wgpr;
    assign wb_bus.mem_to_reg = wb_m2r;
    assign wb_bus.data       = wb_data;

endmodule

// File: pipe_top.sv
// ==========================================================
// pipe_top
// integer back end: issue, ID-EX segment register,
// EX/MEM/WB and the forward and stall unit
// ==========================================================
module pipe_top #(
    parameter int MEM_DEPTH = 64,
    parameter int MEM_LAT   = 2
) (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        instr_valid,
    input  logic [isa_pkg::XLEN-1:0]    instr,
    output logic                        instr_ready,
    output logic                        wb_valid,
    output logic [isa_pkg::REG_AW-1:0]  wb_rd,
    output logic [isa_pkg::XLEN-1:0]    wb_data
);
    import isa_pkg::*;
    import pipe_pkg::*;

    ex_ctrl_t          id_ctrl, ex_ctrl;
    logic [REG_AW-1:0] id_rs1, id_rs2;
    logic [XLEN-1:0]   id_rs1_data, id_rs2_data, op_a, op_b, mem_rdata;
    logic              stall, flush_me, mem_rvalid, mem_wready;
    logic              ex_hazard_rs1, ex_hazard_rs2, seg_hazard_rs1, seg_hazard_rs2;
    logic [XLEN-1:0]   ex_data_rs1, ex_data_rs2, seg_data_rs1, seg_data_rs2;

    stage_if mem_bus ();
    stage_if wb_bus ();

    issue_stage i_issue_stage (
        .clk(clk), .arst_n(arst_n), .instr_valid(instr_valid), .instr(instr),
        .stall(stall), .wb(wb_bus), .rs1(id_rs1), .rs2(id_rs2), .ctrl(id_ctrl),
        .rs1_data(id_rs1_data), .rs2_data(id_rs2_data)
    );

    ex_seg_reg i_ex_seg_reg (
        .clk(clk), .arst_n(arst_n), .stall(stall), .ctrl_in(id_ctrl),
        .rs1_data_in(id_rs1_data), .rs2_data_in(id_rs2_data),
        .seg_hazard_rs1(seg_hazard_rs1), .seg_hazard_rs2(seg_hazard_rs2),
        .seg_data_rs1(seg_data_rs1), .seg_data_rs2(seg_data_rs2),
        .ctrl_out(ex_ctrl), .op_a(op_a), .op_b(op_b)
    );

    mem_forward i_mem_forward (
        .instr_valid(instr_valid), .mem_rvalid(mem_rvalid), .mem_wready(mem_wready),
        .id_rs1(id_rs1), .id_rs2(id_rs2), .ex_rs1(ex_ctrl.rs1), .ex_rs2(ex_ctrl.rs2),
        .mem_bus(mem_bus), .wb_bus(wb_bus), .mem_rdata(mem_rdata),
        .stall(stall), .flush_me(flush_me),
        .ex_hazard_rs1(ex_hazard_rs1), .ex_hazard_rs2(ex_hazard_rs2),
        .ex_data_rs1(ex_data_rs1), .ex_data_rs2(ex_data_rs2),
        .seg_hazard_rs1(seg_hazard_rs1), .seg_hazard_rs2(seg_hazard_rs2),
        .seg_data_rs1(seg_data_rs1), .seg_data_rs2(seg_data_rs2)
    );

    exec_mem_wb #(.MEM_DEPTH(MEM_DEPTH), .MEM_LAT(MEM_LAT)) i_exec_mem_wb (
        .clk(clk), .arst_n(arst_n), .stall(stall), .flush_me(flush_me),
        .ctrl(ex_ctrl), .op_a(op_a), .op_b(op_b),
        .ex_hazard_rs1(ex_hazard_rs1), .ex_hazard_rs2(ex_hazard_rs2),
        .ex_data_rs1(ex_data_rs1), .ex_data_rs2(ex_data_rs2),
        .mem_bus(mem_bus), .wb_bus(wb_bus), .mem_rdata(mem_rdata),
        .mem_rvalid(mem_rvalid), .mem_wready(mem_wready)
    );

    // word is taken whenever the pipe moves
    assign instr_ready = ~stall;
    assign wb_valid    = wb_bus.write_gpr;
    assign wb_rd       = wb_bus.rd;
    assign wb_data     = wb_bus.data;

endmodule

// File: pipe_asserts.sv
// ==========================================================
// pipe_asserts
// concurrent checks on the back end's control outputs,
// bound into the top level
// ==========================================================
module pipe_asserts (
    input logic                        clk,
    input logic                        arst_n,
    input logic                        instr_valid,
    input logic                        instr_ready,
    input logic                        wb_valid,
    input logic [isa_pkg::REG_AW-1:0]  wb_rd
);
    int violations;

    initial begin
        violations = 0;
    end

    // x0 is never written back
    no_x0_strobe: assert property (@(posedge clk) disable iff (!arst_n)
        wb_valid |-> (wb_rd != '0))
        else begin
            $error("write-back strobe with destination x0");
            violations++;
        end

    // no ready without a fetch word
    ready_needs_valid: assert property (@(posedge clk) disable iff (!arst_n)
        !instr_valid |-> !instr_ready)
        else begin
            $error("instr_ready high while instr_valid is low");
            violations++;
        end

    quiet_in_reset: assert property (@(posedge clk) !arst_n |-> !wb_valid)
        else begin
            $error("wb_valid high during reset");
            violations++;
        end

endmodule

bind pipe_top pipe_asserts i_pipe_asserts (
    .clk(clk),
    .arst_n(arst_n),
    .instr_valid(instr_valid),
    .instr_ready(instr_ready),
    .wb_valid(wb_valid),
    .wb_rd(wb_rd)
);

// File: tb_pipe.sv
// ==========================================================
// tb_pipe
// testbench for the integer back end: directed hazard
// tests, random mixes, reference model and write-back checks
// ==========================================================
module tb_pipe;
    import isa_pkg::*;

    localparam int MEM_DEPTH   = 64;
    localparam int MEM_LAT     = 2;
    localparam int N_GAP       = 40;
    localparam int N_RAND      = 200;
    // directed tests, init stores and padding stay under 64 words
    localparam int TOTAL_WORDS = 64 + N_GAP + N_RAND;
    localparam int TIMEOUT_CYC = 40 * TOTAL_WORDS * (MEM_LAT + 4);

    logic              clk;
    logic              arst_n;
    logic              instr_valid;
    logic [XLEN-1:0]   instr;
    logic              instr_ready;
    logic              wb_valid;
    logic [REG_AW-1:0] wb_rd;
    logic [XLEN-1:0]   wb_data;
    logic              took;

    // architectural state of the reference model
    logic [XLEN-1:0]   arch_gpr [NUM_GPR];
    logic [XLEN-1:0]   arch_mem [MEM_DEPTH];
    logic [REG_AW-1:0] exp_rd_q [$];
    logic [XLEN-1:0]   exp_data_q [$];
    int                seed;
    int                errors;
    int                checks;
    int                tests;
    int                err_base;
    int                chk_base;
    string             test_name;

    pipe_top #(.MEM_DEPTH(MEM_DEPTH), .MEM_LAT(MEM_LAT)) i_pipe_top (
        .clk(clk), .arst_n(arst_n), .instr_valid(instr_valid), .instr(instr),
        .instr_ready(instr_ready), .wb_valid(wb_valid), .wb_rd(wb_rd), .wb_data(wb_data)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // word is taken on the edge where valid meets ready
    always @(posedge clk) begin
        took <= instr_valid && instr_ready;
    end

    function automatic logic [XLEN-1:0] encode(input op_e op, input int rd, input int rs1,
                                               input int rs2, input int imm);
        return {op, rd[REG_AW-1:0], rs1[REG_AW-1:0], rs2[REG_AW-1:0], 1'b0, imm[11:0]};
    endfunction

    // few registers, so hazards are frequent; memory ops use x0 as base
    function automatic logic [XLEN-1:0] rand_word(input bit use_mem);
        int  pick;
        int  rd;
        int  rs1;
        int  rs2;
        int  imm;
        op_e op;
        pick = int'($unsigned($random(seed)) % (use_mem ? 8 : 6));
        op   = op_e'(pick[3:0]);
        rd   = int'($unsigned($random(seed)) % 4);
        rs1  = int'($unsigned($random(seed)) % 4);
        rs2  = int'($unsigned($random(seed)) % 4);
        imm  = $random(seed);
        if (op == OP_LW || op == OP_SW) begin
            rs1 = 0;
            imm = 4 * int'($unsigned($random(seed)) % 8);
        end
        return encode(op, rd, rs1, rs2, imm);
    endfunction

    // executes one accepted word and queues its expected write-back
    function automatic void ref_execute(input logic [XLEN-1:0] word);
        op_e               op;
        logic [REG_AW-1:0] rd;
        logic [XLEN-1:0]   a;
        logic [XLEN-1:0]   b;
        logic [XLEN-1:0]   imm;
        logic [XLEN-1:0]   res;
        int                idx;
        bit                writes;
        op     = op_e'(word[31:28]);
        rd     = word[27:23];
        a      = arch_gpr[word[22:18]];
        b      = arch_gpr[word[17:13]];
        imm    = {{20{word[11]}}, word[11:0]};
        idx    = int'(((a + imm) >> 2) % MEM_DEPTH);
        res    = '0;
        writes = 1'b1;
        case (op)
            OP_ADD:  res = a + b;
            OP_SUB:  res = a - b;
            OP_AND:  res = a & b;
            OP_OR:   res = a | b;
            OP_XOR:  res = a ^ b;
            OP_ADDI: res = a + imm;
            OP_LW:   res = arch_mem[idx];
            OP_SW: begin
                arch_mem[idx] = b;
                writes        = 1'b0;
            end
            default: writes = 1'b0;
        endcase
        if (writes && rd != '0) begin
            arch_gpr[rd] = res;
            exp_rd_q.push_back(rd);
            exp_data_q.push_back(res);
        end
    endfunction

    task automatic check_rd(input logic [REG_AW-1:0] exp, input logic [REG_AW-1:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[FAIL] %s: wb_rd expected x%0d actual x%0d", test_name, exp, act);
        end
    endtask

    task automatic check_data(input logic [XLEN-1:0] exp, input logic [XLEN-1:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[FAIL] %s: wb_data expected %h actual %h", test_name, exp, act);
        end
    endtask

    // outputs are registered, so the falling edge sees them settled
    always @(negedge clk) begin
        if (arst_n && wb_valid) begin
            if (exp_rd_q.size() == 0) begin
                errors++;
                $display("%s: write-back to x%0d with no instruction outstanding",
                         test_name, wb_rd);
            end else begin
                check_rd(exp_rd_q.pop_front(), wb_rd);
                check_data(exp_data_q.pop_front(), wb_data);
            end
        end
    end

    task automatic send_word(input logic [XLEN-1:0] word);
        instr_valid = 1'b1;
        instr       = word;
        @(negedge clk);
        while (!took) begin
            @(negedge clk);
        end
        ref_execute(word);
    endtask

    task automatic idle(input int cycles);
        instr_valid = 1'b0;
        repeat (cycles) @(negedge clk);
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        err_base  = errors;
        chk_base  = checks;
    endtask

    // pipe only advances on new words, so push nops until all results are back
    task automatic end_test();
        while (exp_rd_q.size() != 0) begin
            send_word(encode(OP_ADDI, 0, 0, 0, 0));
        end
        instr_valid = 1'b0;
        tests++;
        $display("test %s: %0d checks, %0d errors", test_name, checks - chk_base,
                 errors - err_base);
    endtask

    initial begin
        repeat (TIMEOUT_CYC) @(posedge clk);
        $display("timeout: run did not finish within %0d clock cycles", TIMEOUT_CYC);
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin
        seed        = 17;
        errors      = 0;
        checks      = 0;
        tests       = 0;
        test_name   = "reset";
        arst_n      = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        for (int i = 0; i < NUM_GPR; i++) begin
            arch_gpr[i] = '0;
        end
        for (int i = 0; i < MEM_DEPTH; i++) begin
            arch_mem[i] = '0;
        end
        repeat (10) @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);

        // first and second stage bypass on a dependent chain
        begin_test("alu_bypass");
        send_word(encode(OP_ADDI, 1, 0, 0, 5));
        send_word(encode(OP_ADD, 2, 1, 1, 0));
        send_word(encode(OP_ADD, 3, 1, 2, 0));
        send_word(encode(OP_SUB, 4, 3, 1, 0));
        send_word(encode(OP_XOR, 5, 4, 2, 0));
        send_word(encode(OP_AND, 6, 5, 3, 0));
        send_word(encode(OP_OR, 7, 6, 4, 0));
        end_test();

        begin_test("load_use");
        send_word(encode(OP_ADDI, 1, 0, 0, 'h123));
        send_word(encode(OP_SW, 0, 0, 1, 16));
        send_word(encode(OP_LW, 2, 0, 0, 16));
        send_word(encode(OP_ADD, 3, 2, 2, 0));
        send_word(encode(OP_LW, 4, 0, 0, 16));
        send_word(encode(OP_ADDI, 5, 4, 0, 1));
        send_word(encode(OP_SW, 0, 0, 5, 20));
        send_word(encode(OP_LW, 6, 0, 0, 20));
        send_word(encode(OP_SUB, 7, 6, 4, 0));
        end_test();

        // reader three slots behind the writer
        begin_test("seg_capture");
        send_word(encode(OP_ADDI, 8, 0, 0, 77));
        send_word(encode(OP_ADDI, 0, 0, 0, 0));
        send_word(encode(OP_ADDI, 0, 0, 0, 0));
        send_word(encode(OP_ADD, 9, 8, 8, 0));
        send_word(encode(OP_ADDI, 10, 0, 0, -3));
        send_word(encode(OP_ADDI, 0, 0, 0, 0));
        send_word(encode(OP_ADDI, 0, 0, 0, 0));
        send_word(encode(OP_SUB, 11, 10, 9, 0));
        end_test();

        begin_test("mem_priority");
        send_word(encode(OP_ADDI, 12, 0, 0, 1));
        send_word(encode(OP_ADDI, 12, 0, 0, 2));
        send_word(encode(OP_ADD, 13, 12, 12, 0));
        send_word(encode(OP_ADDI, 12, 0, 0, 9));
        send_word(encode(OP_ADDI, 12, 12, 0, 1));
        send_word(encode(OP_ADD, 14, 12, 0, 0));
        end_test();

        begin_test("valid_gaps");
        for (int i = 0; i < N_GAP; i++) begin
            if ($unsigned($random(seed)) % 3 == 0) begin
                idle(1 + int'($unsigned($random(seed)) % 3));
            end
            send_word(rand_word(1'b0));
        end
        end_test();

        // every word that a load can reach is written first
        begin_test("random_mix");
        for (int i = 0; i < 8; i++) begin
            send_word(encode(OP_SW, 0, 0, 0, 4 * i));
        end
        for (int i = 0; i < N_RAND; i++) begin
            send_word(rand_word(1'b1));
        end
        end_test();

        $display("tests %0d, checks %0d, errors %0d, assertion failures %0d", tests, checks,
                 errors, i_pipe_top.i_pipe_asserts.violations);
        if (errors == 0 && i_pipe_top.i_pipe_asserts.violations == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// File: files.f
isa_pkg.sv
pipe_pkg.sv
stage_if.sv
issue_stage.sv
ex_seg_reg.sv
mem_forward.sv
exec_mem_wb.sv
pipe_top.sv
pipe_asserts.sv
tb_pipe.sv

// File: run.sh
#!/bin/sh
# build the testbench with Verilator, run it and check the log
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -j 0 --top-module tb_pipe -f files.f -o sim_pipe
./obj_dir/sim_pipe +verilator+error+limit+100 | tee sim.log
if grep -qx "Simulation finished: PASS" sim.log; then
    echo "run.sh: simulation passed"
else
    echo "run.sh: simulation failed"
    exit 1
fi
